/* verilog.f */
+incdir+sim
verilog/nanorv32_pkg.sv
verilog/bytewrite_ram_32bits.sv
verilog/nanorv32_regfile.sv
verilog/nanorv32_pc.sv
verilog/nanorv32_exec.sv
verilog/nanorv32_ctrl.sv
verilog/nanorv32.sv
verilog/nanorv32_simple.sv
sim/tb_nanorv32_simple.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the nanorv32_simple testbench with Verilator, run from any directory

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_nanorv32_simple \
   --Mdir "$BUILD_DIR" -o tb_nanorv32_simple
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/tb_nanorv32_simple" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sim/tb_nanorv32_model.svh */
/* Random program generator and instruction-level reference model
   Uses only x0..x7 with x1 as data base pointer; loads read only words stored earlier */
`ifndef TB_NANORV32_MODEL_SVH
`define TB_NANORV32_MODEL_SVH

localparam int          N_INSTR = 40;
localparam logic [31:0] SEED    = 32'hdde6_3090;

logic [31:0] lcg_state;
logic [31:0] prog     [0:N_INSTR-1];
logic [31:0] mregs    [0:31];
logic [7:0]  mmem     [0:255];           // 256-byte window above the base
logic [31:0] exp_addr [0:N_INSTR-1];
logic [31:0] exp_data [0:N_INSTR-1];
logic [3:0]  exp_sel  [0:N_INSTR-1];
int          exp_count;
int          exp_retired;

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Upper half only, the low LCG bits repeat quickly
function automatic int pick(input int n);
   logic [31:0] r;
   r = lcg_next();
   return int'(r[31:16]) % n;
endfunction

function automatic logic [4:0] dest_reg();
   return 5'(2 + pick(6));               // x1 stays the base
endfunction

function automatic logic [4:0] source_reg();
   return 5'(pick(8));
endfunction

task automatic gen_program();
   instr_u      w;
   logic [11:0] off;
   logic [63:0] safe;                    // Words written by an SW that always runs
   logic [4:0]  rd;
   int          k, kind, skip, shadow_end, idx;
   lcg_state  = SEED;
   safe       = '0;
   shadow_end = 0;
   k          = 0;
   while (k < N_INSTR - 1) begin
      w    = '0;
      kind = (k < 7) ? 10 : pick(10);
      if (kind == 7 && (safe == '0 || k > N_INSTR - 3))
         kind = 5;                       // Nothing safe to load yet
      if (kind == 8 && k > N_INSTR - 3)
         kind = 3;
      case (kind)
         10: begin                       // Register init, x1 gets the base
            w.i.opcode  = OPC_OP_IMM;
            w.i.rd      = 5'(k + 1);
            w.i.imm11_0 = (k == 0) ? 12'h200 : 12'(pick(4096));
         end
         0: begin
            w.u.opcode   = OPC_LUI;
            w.u.rd       = dest_reg();
            w.u.imm31_12 = 20'(lcg_next() >> 12);
         end
         1, 2: begin
            w.i.opcode  = OPC_OP_IMM;
            w.i.rd      = dest_reg();
            w.i.rs1     = source_reg();
            w.i.imm11_0 = 12'(pick(4096));
         end
         5, 6: begin                     // SW or SB off the base
            off         = 12'((kind == 5) ? 4 * pick(64) : pick(256));
            w.s.opcode  = OPC_STORE;
            w.s.funct3  = (kind == 5) ? 3'b010 : 3'b000;
            w.s.rs1     = 5'd1;
            w.s.rs2     = source_reg();
            w.s.imm11_5 = off[11:5];
            w.s.imm4_0  = off[4:0];
            if (kind == 5 && k > shadow_end)
               safe[off[7:2]] = 1'b1;
         end
         7: begin                        // LW, then SW of the loaded value
            idx = pick(64);
            while (!safe[idx])
               idx = (idx + 1) % 64;
            rd          = dest_reg();
            w.i.opcode  = OPC_LOAD;
            w.i.funct3  = 3'b010;
            w.i.rd      = rd;
            w.i.rs1     = 5'd1;
            w.i.imm11_0 = 12'(4 * idx);
            prog[k]     = w;
            k++;
            off         = 12'(4 * pick(64));
            w           = '0;
            w.s.opcode  = OPC_STORE;
            w.s.funct3  = 3'b010;
            w.s.rs1     = 5'd1;
            w.s.rs2     = rd;
            w.s.imm11_5 = off[11:5];
            w.s.imm4_0  = off[4:0];
            if (k > shadow_end)
               safe[off[7:2]] = 1'b1;
         end
         8: begin                        // Forward BEQ/BNE over 1..3 words
            skip = 1 + pick(3);
            if (k + 1 + skip > N_INSTR - 1)
               skip = N_INSTR - 2 - k;
            off         = 12'(4 * (skip + 1));
            w.b.opcode  = OPC_BRANCH;
            w.b.funct3  = (pick(2) == 1) ? 3'b001 : 3'b000;
            w.b.rs1     = source_reg();
            w.b.rs2     = (pick(2) == 1) ? w.b.rs1 : source_reg();
            w.b.imm10_5 = off[10:5];
            w.b.imm4_1  = off[4:1];
            if (k + skip > shadow_end)
               shadow_end = k + skip;
         end
         default: begin                  // ADD SUB AND OR XOR
            idx        = pick(5);
            w.r.opcode = OPC_OP;
            w.r.rd     = dest_reg();
            w.r.rs1    = source_reg();
            w.r.rs2    = source_reg();
            w.r.funct3 = (idx == 2) ? 3'b111 : (idx == 3) ? 3'b110 :
                         (idx == 4) ? 3'b100 : 3'b000;
            w.r.funct7 = (idx == 1) ? 7'b0100000 : 7'b0000000;
         end
      endcase
      prog[k] = w;
      k++;
   end
   w          = '0;
   w.j.opcode = OPC_JAL;                 // Offset zero, halts
   prog[N_INSTR-1] = w;
endtask

task automatic run_model();
   instr_u      w;
   logic [31:0] pc, a, b, imm, res, next_pc;
   logic        wb, done;
   int          o;
   pc          = '0;
   done        = 1'b0;
   exp_count   = 0;
   exp_retired = 0;
   for (int r = 0; r < 32; r++)
      mregs[r] = '0;
   while (!done && exp_retired < N_INSTR) begin
      w       = prog[pc[7:2]];
      a       = mregs[w.r.rs1];
      b       = mregs[w.r.rs2];
      wb      = 1'b0;
      res     = '0;
      next_pc = pc + 32'd4;
      exp_retired++;
      case (w.r.opcode)
         OPC_LUI: begin
            res = {w.u.imm31_12, 12'h000};
            wb  = 1'b1;
         end
         OPC_OP_IMM: begin               // Only ADDI is generated
            res = a + {{20{w.i.imm11_0[11]}}, w.i.imm11_0};
            wb  = 1'b1;
         end
         OPC_OP: begin
            case (w.r.funct3)
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               3'b111:  res = a & b;
               default: res = w.r.funct7[5] ? a - b : a + b;
            endcase
            wb = 1'b1;
         end
         OPC_LOAD: begin
            res = a + {{20{w.i.imm11_0[11]}}, w.i.imm11_0};
            o   = int'(res[7:0]);
            res = {mmem[o+3], mmem[o+2], mmem[o+1], mmem[o]};   // Little endian
            wb  = 1'b1;
         end
         OPC_STORE: begin
            res = a + {{20{w.s.imm11_5[6]}}, w.s.imm11_5, w.s.imm4_0};
            o   = int'(res[7:0]);
            exp_addr[exp_count] = res;
            if (w.s.funct3 == 3'b010) begin
               exp_sel[exp_count]  = 4'b1111;
               exp_data[exp_count] = b;
               for (int i = 0; i < 4; i++)
                  mmem[o+i] = b[8*i +: 8];
            end else begin
               exp_sel[exp_count]  = 4'b0001 << res[1:0];
               exp_data[exp_count] = {4{b[7:0]}};
               mmem[o] = b[7:0];
            end
            exp_count++;
         end
         OPC_BRANCH: begin
            imm = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
            if ((a == b) != w.b.funct3[0])
               next_pc = pc + imm;
         end
         OPC_JAL: begin
            imm = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
            res = pc + 32'd4;
            wb  = 1'b1;
            if (imm == '0)
               done = 1'b1;
            else
               next_pc = pc + imm;
         end
         default: ;                      // No-op
      endcase
      if (wb && w.r.rd != 5'd0)
         mregs[w.r.rd] = res;
      pc = next_pc;
   end
endtask

`endif

/* sim/tb_nanorv32_simple.sv */
/* Testbench for nanorv32_simple with AW = 15, random program and random ready stalls
   Stores and retired count are compared with the model in the included header */
`timescale 1ns/10ps

module tb_nanorv32_simple;
   import nanorv32_pkg::*;

   localparam int AW = 15;

   logic              clk = 1'b0;
   logic              rst_n, run, codemem_cpu_ready, datamem_cpu_ready, prog_we;
   logic [AW-1:0]     prog_addr;
   logic [DATA_W-1:0] prog_wdata;
   logic              cpu_codemem_valid, cpu_datamem_valid, store_strobe, halted;
   logic [31:0]       cpu_datamem_addr, cpu_datamem_wdata, retired;
   logic [3:0]        cpu_datamem_bytesel;
   int                value_errors = 0;
   int                other_errors = 0;
   int                store_idx = 0;
   int                fetch_count = 0;
   int                cycle_count = 0;
   logic              halt_seen = 1'b0;
   logic              fetch_prev = 1'b0;
   logic [31:0]       mask;

   `include "tb_nanorv32_model.svh"

   // 5 cycles per instruction, up to 4x with stalls, margin for reset and load
   localparam int TIMEOUT_CYCLES = N_INSTR * 5 * 4 + 200;

   nanorv32_simple #(.AW(AW)) i_dut (
      .clk(clk), .rst_n(rst_n), .run(run),
      .codemem_cpu_ready(codemem_cpu_ready), .datamem_cpu_ready(datamem_cpu_ready),
      .prog_we(prog_we), .prog_addr(prog_addr), .prog_wdata(prog_wdata),
      .cpu_codemem_valid(cpu_codemem_valid), .cpu_datamem_valid(cpu_datamem_valid),
      .cpu_datamem_addr(cpu_datamem_addr), .cpu_datamem_wdata(cpu_datamem_wdata),
      .cpu_datamem_bytesel(cpu_datamem_bytesel), .store_strobe(store_strobe),
      .halted(halted), .retired(retired)
   );

   always #10 clk = ~clk;                // 20 ns period

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_bytesel(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   function automatic logic [31:0] lane_mask(input logic [3:0] sel);
      return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
   endfunction

   task automatic print_counts();
      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
   endtask

   // Ready levels, high 3 times in 4 once the core runs
   initial begin
      codemem_cpu_ready = 1'b1;
      datamem_cpu_ready = 1'b1;
      forever begin
         @(posedge clk);
         if (run) begin                  // Run taken at the edge, settled since last edge
            #2;
            codemem_cpu_ready = (pick(4) != 0);
            datamem_cpu_ready = (pick(4) != 0);
         end
      end
   end

   // Store monitor, sampled mid-cycle
   always @(negedge clk) begin
      if (halted === 1'b1)
         halt_seen = 1'b1;
      // One rising edge of the fetch valid per instruction, held through stalls
      if (cpu_codemem_valid === 1'b1 && !fetch_prev)
         fetch_count++;
      fetch_prev = (cpu_codemem_valid === 1'b1);
      if (store_strobe === 1'b1) begin
         if (halt_seen) begin
            $display("A store was issued after the core halted");
            other_errors++;
         end else if (store_idx >= exp_count) begin
            $display("Store number %0d seen, model expects only %0d", store_idx + 1, exp_count);
            other_errors++;
         end else begin
            mask = lane_mask(exp_sel[store_idx]);
            check_word("cpu_datamem_addr", cpu_datamem_addr, exp_addr[store_idx]);
            check_word("cpu_datamem_wdata", cpu_datamem_wdata & mask,
                       exp_data[store_idx] & mask);
            check_bytesel("cpu_datamem_bytesel", cpu_datamem_bytesel, exp_sel[store_idx]);
         end
         store_idx++;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout, core did not halt within %0d cycles", TIMEOUT_CYCLES);
         print_counts();
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      rst_n      = 1'b0;
      run        = 1'b0;
      prog_we    = 1'b0;
      prog_addr  = '0;
      prog_wdata = '0;
      gen_program();
      run_model();
      repeat (3) @(posedge clk);
      #2 rst_n = 1'b1;
      // Fill the code RAM while the core idles
      for (int k = 0; k < N_INSTR; k++) begin
         @(posedge clk);
         #2;
         prog_we    = 1'b1;
         prog_addr  = AW'(4 * k);
         prog_wdata = prog[k];
         @(negedge clk);
         check_flag("cpu_codemem_valid", cpu_codemem_valid, 1'b0);
         check_flag("cpu_datamem_valid", cpu_datamem_valid, 1'b0);
         check_flag("store_strobe", store_strobe, 1'b0);
         check_bytesel("cpu_datamem_bytesel", cpu_datamem_bytesel, 4'b0000);
         check_flag("halted", halted, 1'b0);
      end
      @(posedge clk);
      #2;
      prog_we = 1'b0;
      run     = 1'b1;
      while (halted !== 1'b1)
         @(negedge clk);
      repeat (10) @(negedge clk);        // Watch for stray stores
      #1;
      check_flag("halted", halted, 1'b1);
      check_word("retired", retired, 32'(exp_retired));
      if (store_idx != exp_count) begin
         $display("Core issued %0d stores, model expects %0d", store_idx, exp_count);
         other_errors++;
      end
      if (fetch_count != exp_retired) begin
         $display("Core fetched %0d instructions, model executes %0d", fetch_count, exp_retired);
         other_errors++;
      end
      print_counts();
      if (value_errors == 0 && other_errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* verilog/nanorv32_simple.sv */
/* Core plus separate code and data RAMs, each 2**AW bytes, no address decoding
   Load port writes the code RAM only while run is low */
`timescale 1ns/10ps

module nanorv32_simple #(
   parameter int AW = 15                          // 32 KB per RAM
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              run,
   input  logic                              codemem_cpu_ready,
   input  logic                              datamem_cpu_ready,
   input  logic                              prog_we,
   input  logic [AW-1:0]                     prog_addr,   // Byte address
   input  logic [nanorv32_pkg::DATA_W-1:0]   prog_wdata,
   output logic                              cpu_codemem_valid,
   output logic                              cpu_datamem_valid,
   output logic [31:0]                       cpu_datamem_addr,
   output logic [31:0]                       cpu_datamem_wdata,
   output logic [3:0]                        cpu_datamem_bytesel,
   output logic                              store_strobe,
   output logic                              halted,
   output logic [31:0]                       retired
);
   import nanorv32_pkg::*;

   logic [DATA_W-1:0] codemem_cpu_rdata;
   logic [DATA_W-1:0] datamem_cpu_rdata;
   logic [31:0]       cpu_codemem_addr;
   logic              is_store;
   logic [AW-3:0]     code_addr;
   logic [3:0]        we_codemem;
   logic [3:0]        we_datamem;

   nanorv32 u_cpu (
      .clk                 (clk),
      .rst_n               (rst_n),
      .run                 (run),
      .codemem_cpu_rdata   (codemem_cpu_rdata),
      .codemem_cpu_ready   (codemem_cpu_ready),
      .datamem_cpu_rdata   (datamem_cpu_rdata),
      .datamem_cpu_ready   (datamem_cpu_ready),
      .cpu_codemem_addr    (cpu_codemem_addr),
      .cpu_codemem_valid   (cpu_codemem_valid),
      .cpu_datamem_addr    (cpu_datamem_addr),
      .cpu_datamem_wdata   (cpu_datamem_wdata),
      .cpu_datamem_bytesel (cpu_datamem_bytesel),
      .cpu_datamem_valid   (cpu_datamem_valid),
      .is_store            (is_store),
      .halted              (halted),
      .retired             (retired)
   );

   // Load port owns the code RAM while the core is idle
   assign code_addr  = run ? cpu_codemem_addr[AW-1:2] : prog_addr[AW-1:2];
   assign we_codemem = {4{prog_we & ~run}};     // Whole words only

   bytewrite_ram_32bits #(.AW(AW)) u_code_mem (
      .clk  (clk),
      .we   (we_codemem),
      .addr (code_addr),
      .din  (prog_wdata),
      .dout (codemem_cpu_rdata)
   );

   // Byte enables only in the single store issue cycle
   assign we_datamem   = cpu_datamem_bytesel & {4{cpu_datamem_valid & is_store}};
   assign store_strobe = cpu_datamem_valid & is_store;

   bytewrite_ram_32bits #(.AW(AW)) u_data_mem (
      .clk  (clk),
      .we   (we_datamem),
      .addr (cpu_datamem_addr[AW-1:2]),
      .din  (cpu_datamem_wdata),
      .dout (datamem_cpu_rdata)
   );

endmodule

/* verilog/nanorv32.sv */
/* Multi-cycle RV32I subset core, one instruction in flight
   Addresses are full 32-bit byte addresses, the RAMs use the low bits */
`timescale 1ns/10ps

module nanorv32 (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            run,
   input  logic [nanorv32_pkg::DATA_W-1:0] codemem_cpu_rdata,
   input  logic                            codemem_cpu_ready,
   input  logic [nanorv32_pkg::DATA_W-1:0] datamem_cpu_rdata,
   input  logic                            datamem_cpu_ready,
   output logic [31:0]                     cpu_codemem_addr,
   output logic                            cpu_codemem_valid,
   output logic [31:0]                     cpu_datamem_addr,
   output logic [nanorv32_pkg::DATA_W-1:0] cpu_datamem_wdata,
   output logic [3:0]                      cpu_datamem_bytesel,
   output logic                            cpu_datamem_valid,
   output logic                            is_store,
   output logic                            halted,
   output logic [31:0]                     retired
);
   import nanorv32_pkg::*;

   instr_u            ir;
   opcode_t           opcode;
   logic              ir_load, pc_update, rf_we, wb_from_mem;
   logic              take_target, halt_jump;
   logic [31:0]       pc, target;
   logic [DATA_W-1:0] rs1_val, rs2_val, alu_result, rf_wdata;

   // Cleared so the decode of an idle core shows no store
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         ir <= '0;
      else if (ir_load)
         ir <= codemem_cpu_rdata;
   end

   nanorv32_ctrl u_ctrl (
      .clk(clk), .rst_n(rst_n), .run(run), .opcode(opcode),
      .codemem_cpu_ready(codemem_cpu_ready), .datamem_cpu_ready(datamem_cpu_ready),
      .halt_jump(halt_jump), .cpu_codemem_valid(cpu_codemem_valid),
      .cpu_datamem_valid(cpu_datamem_valid), .ir_load(ir_load), .pc_update(pc_update),
      .rf_we(rf_we), .wb_from_mem(wb_from_mem), .is_store(is_store), .halted(halted)
   );

   nanorv32_pc u_pc (
      .clk(clk), .rst_n(rst_n), .pc_update(pc_update), .take_target(take_target),
      .target(target), .pc(pc), .retired(retired)
   );

   assign rf_wdata = wb_from_mem ? datamem_cpu_rdata : alu_result;  // Load or ALU result

   nanorv32_regfile u_regfile (
      .clk(clk), .rs1(ir.r.rs1), .rs2(ir.r.rs2), .rd(ir.r.rd), .we(rf_we),
      .wdata(rf_wdata), .rdata1(rs1_val), .rdata2(rs2_val)
   );

   nanorv32_exec u_exec (
      .instr(ir), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
      .alu_result(alu_result), .take_target(take_target), .target(target),
      .halt_jump(halt_jump), .opcode(opcode), .bytesel(cpu_datamem_bytesel),
      .store_data(cpu_datamem_wdata)
   );

   assign cpu_codemem_addr = pc;
   assign cpu_datamem_addr = alu_result;     // rs1 + offset for LW/SW/SB

endmodule

/* verilog/nanorv32_ctrl.sv */
/* Control FSM, 3 cycles per ALU/branch/jump and 5 per load/store at full ready
   Each low ready cycle in IWAIT or DWAIT adds one; run is only sampled in IDLE */
`timescale 1ns/10ps

module nanorv32_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  run,
   input  nanorv32_pkg::opcode_t opcode,
   input  logic                  codemem_cpu_ready,
   input  logic                  datamem_cpu_ready,
   input  logic                  halt_jump,
   output logic                  cpu_codemem_valid,
   output logic                  cpu_datamem_valid,
   output logic                  ir_load,
   output logic                  pc_update,
   output logic                  rf_we,
   output logic                  wb_from_mem,
   output logic                  is_store,
   output logic                  halted
);
   import nanorv32_pkg::*;

   localparam logic [2:0] S_IDLE  = 3'd0;
   localparam logic [2:0] S_FETCH = 3'd1;
   localparam logic [2:0] S_IWAIT = 3'd2;
   localparam logic [2:0] S_EXEC  = 3'd3;
   localparam logic [2:0] S_MEM   = 3'd4;
   localparam logic [2:0] S_DWAIT = 3'd5;
   localparam logic [2:0] S_HALT  = 3'd6;

   logic [2:0] state, state_nxt;
   logic       is_mem, writes_rd;

   assign is_mem    = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
   assign writes_rd = (opcode == OPC_LUI) || (opcode == OPC_OP_IMM) ||
                      (opcode == OPC_OP)  || (opcode == OPC_JAL);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= S_IDLE;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt         = state;
      cpu_codemem_valid = 1'b0;
      cpu_datamem_valid = 1'b0;
      ir_load           = 1'b0;
      pc_update         = 1'b0;
      rf_we             = 1'b0;
      wb_from_mem       = 1'b0;
      is_store          = 1'b0;
      halted            = 1'b0;
      case (state)
         S_IDLE:  if (run) state_nxt = S_FETCH;
         S_FETCH: begin
            cpu_codemem_valid = 1'b1;            // Address is the pc
            state_nxt         = S_IWAIT;
         end
         S_IWAIT: begin
            cpu_codemem_valid = 1'b1;            // Held until ready
            if (codemem_cpu_ready) begin
               ir_load   = 1'b1;
               state_nxt = S_EXEC;
            end
         end
         S_EXEC: begin
            if (is_mem) begin
               state_nxt = S_MEM;
            end else begin
               // Unknown opcodes just step the pc
               rf_we     = writes_rd;
               pc_update = 1'b1;
               state_nxt = halt_jump ? S_HALT : S_FETCH;
            end
         end
         S_MEM: begin
            cpu_datamem_valid = 1'b1;
            is_store          = (opcode == OPC_STORE);   // Single write cycle
            state_nxt         = S_DWAIT;
         end
         S_DWAIT: begin
            cpu_datamem_valid = 1'b1;
            wb_from_mem       = 1'b1;
            if (datamem_cpu_ready) begin
               rf_we     = (opcode == OPC_LOAD);
               pc_update = 1'b1;
               state_nxt = S_FETCH;
            end
         end
         S_HALT:  halted = 1'b1;                  // Left only by reset
         default: state_nxt = S_IDLE;
      endcase
   end

endmodule

/* verilog/nanorv32_exec.sv */
/* Decode, immediates, ALU, branch decision and store lanes, all combinational
   Only SB and SW stores; byte and halfword loads are not decoded */
`timescale 1ns/10ps

module nanorv32_exec (
   input  nanorv32_pkg::instr_u            instr,
   input  logic [31:0]                     pc,
   input  logic [nanorv32_pkg::DATA_W-1:0] rs1_val,
   input  logic [nanorv32_pkg::DATA_W-1:0] rs2_val,
   output logic [nanorv32_pkg::DATA_W-1:0] alu_result,
   output logic                            take_target,
   output logic [31:0]                     target,
   output logic                            halt_jump,
   output nanorv32_pkg::opcode_t           opcode,
   output logic [3:0]                      bytesel,
   output logic [nanorv32_pkg::DATA_W-1:0] store_data
);
   import nanorv32_pkg::*;

   logic [DATA_W-1:0] imm, op_a, op_b;
   logic [2:0]        funct3;
   alu_op_t           alu_op;
   logic              is_eq;

   assign opcode = opcode_t'(instr.r.opcode);
   assign funct3 = instr.r.funct3;

   // Immediate taken from the member matching the format
   always_comb begin
      case (opcode)
         OPC_LUI:    imm = {instr.u.imm31_12, 12'b0};
         OPC_STORE:  imm = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
         OPC_BRANCH: imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                            instr.b.imm10_5, instr.b.imm4_1, 1'b0};
         OPC_JAL:    imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                            instr.j.imm11, instr.j.imm10_1, 1'b0};
         default:    imm = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};  // I-type, LW
      endcase
   end

   always_comb begin
      op_a   = rs1_val;
      op_b   = imm;
      alu_op = ALU_ADD;                           // Address calc by default
      case (opcode)
         OPC_LUI:    alu_op = ALU_PASS_B;
         OPC_OP, OPC_OP_IMM: begin
            if (opcode == OPC_OP)
               op_b = rs2_val;
            case (funct3)
               3'b100:  alu_op = ALU_XOR;
               3'b110:  alu_op = ALU_OR;
               3'b111:  alu_op = ALU_AND;
               default: alu_op = (opcode == OPC_OP && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            endcase
         end
         OPC_BRANCH: begin
            op_b   = rs2_val;                      // Compare by subtraction
            alu_op = ALU_SUB;
         end
         OPC_JAL: begin
            op_a = pc;                             // Link value pc + 4
            op_b = 32'd4;
         end
         default: ;
      endcase
   end

   always_comb begin
      case (alu_op)
         ALU_SUB:    alu_result = op_a - op_b;
         ALU_AND:    alu_result = op_a & op_b;
         ALU_OR:     alu_result = op_a | op_b;
         ALU_XOR:    alu_result = op_a ^ op_b;
         ALU_PASS_B: alu_result = op_b;
         default:    alu_result = op_a + op_b;
      endcase
   end

   assign is_eq       = (alu_result == '0);
   // BNE has funct3 bit 0 set
   assign take_target = (opcode == OPC_JAL) ||
                        ((opcode == OPC_BRANCH) && (funct3[0] ? !is_eq : is_eq));
   assign target      = pc + imm;
   assign halt_jump   = (opcode == OPC_JAL) && (imm == '0);   // Jump to itself

   // SB picks one lane from the address, SW all four
   always_comb begin
      bytesel = 4'b0000;
      if (opcode == OPC_STORE)
         bytesel = (funct3 == 3'b000) ? (4'b0001 << alu_result[1:0]) : 4'b1111;
   end
   assign store_data = (funct3 == 3'b000) ? {4{rs2_val[7:0]}} : rs2_val;

endmodule

/* verilog/nanorv32_pc.sv */
/* Program counter, zero after reset, and retired-instruction count
   Both advance only on pc_update */
`timescale 1ns/10ps

module nanorv32_pc (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        pc_update,
   input  logic        take_target,
   input  logic [31:0] target,
   output logic [31:0] pc,
   output logic [31:0] retired
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc      <= 32'h0;
         retired <= 32'h0;
      end else if (pc_update) begin
         pc      <= take_target ? target : pc + 32'd4;   // Branch/jump or next word
         retired <= retired + 32'd1;
      end
   end

endmodule

/* verilog/nanorv32_regfile.sv */
/* 32 x 32 register file, asynchronous reads, write on the clock edge
   x0 reads zero and ignores writes */
`timescale 1ns/10ps

module nanorv32_regfile (
   input  logic                            clk,
   input  logic [4:0]                      rs1,
   input  logic [4:0]                      rs2,
   input  logic [4:0]                      rd,
   input  logic                            we,
   input  logic [nanorv32_pkg::DATA_W-1:0] wdata,
   output logic [nanorv32_pkg::DATA_W-1:0] rdata1,
   output logic [nanorv32_pkg::DATA_W-1:0] rdata2
);
   import nanorv32_pkg::*;

   logic [DATA_W-1:0] regs [0:31];

   always_ff @(posedge clk) begin
      if (we && (rd != 5'd0))
         regs[rd] <= wdata;
   end

   // x0 forced at the read side
   assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* verilog/bytewrite_ram_32bits.sv */
/* Single-port RAM of 2**(AW-2) words, registered read, no reset
   Read during write returns the old word */
`timescale 1ns/10ps

module bytewrite_ram_32bits #(
   parameter int AW = 15                 // Byte address width
) (
   input  logic          clk,
   input  logic [3:0]    we,             // One enable per byte lane
   input  logic [AW-3:0] addr,           // Word index
   input  logic [31:0]   din,
   output logic [31:0]   dout
);

   logic [31:0] mem [0:(1 << (AW-2))-1];

   always_ff @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
         if (we[b])
            mem[addr][8*b +: 8] <= din[8*b +: 8];
      end
      dout <= mem[addr];                 // Data one clock after address
   end

endmodule

/* verilog/nanorv32_pkg.sv */
/* Encodings shared by the core and the testbench model
   Only the RV32I opcodes executed by the core are listed */
package nanorv32_pkg;

   localparam int DATA_W = 32;    // Data and instruction width

   // Major opcodes, bits 6:0 of the word
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B                  // LUI, immediate straight through
   } alu_op_t;

   // One instruction word, viewed in the six base formats
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm11_0;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm11_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm4_0;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic       imm12;
         logic [5:0] imm10_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm4_1;
         logic       imm11;
         logic [6:0] opcode;
      } b;
      struct packed {
         logic [19:0] imm31_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
      struct packed {
         logic       imm20;
         logic [9:0] imm10_1;
         logic       imm11;
         logic [7:0] imm19_12;
         logic [4:0] rd;
         logic [6:0] opcode;
      } j;
   } instr_u;

endpackage
